// ==== fetch_frontend.f ====
+incdir+include
source/rv32i_types.sv
source/instr_queue.sv
source/fetch_unit.sv
source/load_port.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/fetch_frontend.sv
bench/fetch_frontend_asserts.sv
bench/fetch_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_frontend.f \
    --top-module fetch_frontend_tb \
    -Mdir obj_dir -o fetch_frontend_sim

# the log decides, so a stopped simulation still gets its verdict below
./obj_dir/fetch_frontend_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG" || ! grep -q "RESULT: PASS" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

// ==== bench/fetch_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_frontend_settings.svh"

module fetch_frontend_tb
    import rv32i_types::*;
();

    localparam int FETCH_POPS       = 40;
    localparam int NUM_FLUSHES      = 6;
    localparam int POPS_AFTER_FLUSH = 10;
    localparam int NUM_LOADS        = 12;
    localparam int PLANNED_OPS      = `MEM_WORDS + FETCH_POPS + `QUEUE_DEPTH + 16 +
                                      NUM_FLUSHES * (1 + POPS_AFTER_FLUSH) + NUM_LOADS + 20;

    localparam logic [1:0] POP_HOLD   = 2'd0;  // dequeue held low
    localparam logic [1:0] POP_RANDOM = 2'd1;  // pop at random while entries wait
    localparam logic [1:0] POP_FORCE  = 2'd2;  // dequeue held high, even when empty

    logic         clk;
    logic         rst;
    logic         fetch_enable;
    logic         branch_flush;
    addr_t        redirect_pc;
    logic         dequeue;
    queue_entry_t rdata;
    logic         empty;
    logic         load_start;
    addr_t        load_addr;
    logic         load_busy;
    logic         load_done;
    word_t        load_data;
    logic         wr_en;
    addr_t        wr_addr;
    word_t        wr_data;

    integer     seed     = 32'h02710585;
    integer     pop_seed = 32'h02710585;  // separate stream for the pop duty
    word_t      mem_copy [`MEM_WORDS];
    addr_t      exp_pc   = `RESET_PC;
    addr_t      load_q [$];               // loads waiting for load_done
    logic [1:0] pop_mode = POP_HOLD;
    logic       empty_s  = 1'b1;          // empty as seen at the last falling edge
    int         pop_count = 0;
    logic       busy_exp = 1'b0;          // load_busy predicted for this cycle
    logic       done_exp = 1'b0;          // load_done predicted for this cycle

    fetch_frontend fetch_frontend_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_enable (fetch_enable),
        .branch_flush (branch_flush),
        .redirect_pc  (redirect_pc),
        .dequeue      (dequeue),
        .rdata        (rdata),
        .empty        (empty),
        .load_start   (load_start),
        .load_addr    (load_addr),
        .load_busy    (load_busy),
        .load_done    (load_done),
        .load_data    (load_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t expected_word(input addr_t a);
        return mem_copy[a[9:2]];  // word index, byte offset ignored
    endfunction

    function automatic queue_entry_t expected_entry(input addr_t pc);
        return '{pc: pc, instr: expected_word(pc)};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_entry(input queue_entry_t got, input queue_entry_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL @ %0t: popped entry pc %h instr %h, expected pc %h instr %h",
                               $time, got.pc, got.instr, exp.pc, exp.instr));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input addr_t a);
        if (got !== exp) begin
            stop_run($sformatf("FAIL @ %0t: load from %h returned %h, expected %h",
                               $time, a, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL @ %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_run($sformatf("FAIL @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // pop side of the decode stage, decided on what empty showed last cycle
    initial begin
        dequeue = 1'b0;
        forever begin
            @(posedge clk);
            if (rst || pop_mode == POP_HOLD) begin
                dequeue <= 1'b0;
            end else if (pop_mode == POP_FORCE) begin
                dequeue <= 1'b1;
            end else begin
                dequeue <= !empty_s && (($random(pop_seed) & 1) != 0);
            end
        end
    end

    // compare process, all outputs are settled at the falling edge
    always @(negedge clk) begin
        addr_t la;
        if (!rst) begin
            if (branch_flush) begin
                exp_pc = redirect_pc;  // queue emptied, fetch restarts here
            end else if (dequeue && !empty_s) begin
                check_entry(rdata, expected_entry(exp_pc));
                exp_pc = exp_pc + 32'd4;
                pop_count++;
            end
            check_level(load_busy, busy_exp, "load_busy");
            check_level(load_done, done_exp, "load_done");
            if (load_done) begin
                if (load_q.size() == 0) begin
                    stop_run("load_done pulsed while no load was outstanding");
                end else begin
                    la = load_q.pop_front();
                    check_word(load_data, expected_word(la), la);
                end
            end
            // a load is never blocked, so busy lasts one cycle and done follows it
            done_exp = busy_exp;
            busy_exp = load_start && !busy_exp;
        end
        empty_s = empty;
    end

    initial begin
        repeat (40 * PLANNED_OPS + 1000) @(posedge clk);
        stop_run("watchdog expired before the tests finished");
    end

    task automatic preload_memory();
        word_t w;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            @(posedge clk);
            w = $random(seed);
            wr_en    <= 1'b1;
            wr_addr  <= addr_t'(i << 2);
            wr_data  <= w;
            mem_copy[i] = w;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pop_count + n;
        while (pop_count < target) @(posedge clk);
    endtask

    task automatic wait_empty();
        while (!empty_s) @(posedge clk);
    endtask

    // stop fetching, let the read in flight land, then pop everything
    task automatic drain_queue();
        fetch_enable <= 1'b0;
        pop_mode     <= POP_RANDOM;
        repeat (4) @(posedge clk);
        wait_empty();
    endtask

    task automatic run_load(input addr_t a, input bit repeat_start);
        int waited;
        @(posedge clk);
        load_start <= 1'b1;
        load_addr  <= a;
        load_q.push_back(a);
        @(posedge clk);
        if (repeat_start) begin
            load_addr <= a ^ 32'h0000_0100;  // arrives while busy, must be dropped
            @(posedge clk);
        end
        load_start <= 1'b0;
        waited = 0;
        while (load_q.size() != 0) begin
            if (waited == 8) begin
                stop_run("load_done did not arrive for a started load");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin
        int start;
        rst          = 1'b1;
        fetch_enable = 1'b0;
        branch_flush = 1'b0;
        redirect_pc  = '0;
        load_start   = 1'b0;
        load_addr    = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        preload_memory();

        pop_mode     <= POP_RANDOM;  // in-order fetch from the reset pc
        fetch_enable <= 1'b1;
        wait_pops(FETCH_POPS);

        drain_queue();               // back-pressure with dequeue held low
        pop_mode     <= POP_HOLD;
        fetch_enable <= 1'b1;
        repeat (`QUEUE_DEPTH * 3 + 20) @(posedge clk);
        fetch_enable <= 1'b0;
        repeat (4) @(posedge clk);
        start = pop_count;
        pop_mode <= POP_RANDOM;
        wait_empty();
        check_count(pop_count - start, `QUEUE_DEPTH, "entries held by the full queue");
        fetch_enable <= 1'b1;
        wait_pops(8);

        for (int i = 0; i < NUM_FLUSHES; i++) begin
            repeat (1 + ($random(seed) & 15)) @(posedge clk);
            branch_flush <= 1'b1;
            redirect_pc  <= addr_t'($random(seed)) & ~32'h3;
            @(posedge clk);
            branch_flush <= 1'b0;
            wait_pops(POPS_AFTER_FLUSH);
        end

        for (int i = 0; i < NUM_LOADS; i++) begin
            repeat (1 + ($random(seed) & 7)) @(posedge clk);
            run_load(addr_t'($random(seed)) & ~32'h3, 1'b0);
        end
        wait_pops(8);

        drain_queue();               // dequeue on an empty queue
        start = pop_count;
        pop_mode <= POP_FORCE;
        repeat (4) @(posedge clk);
        pop_mode <= POP_RANDOM;
        repeat (2) @(posedge clk);
        check_count(pop_count - start, 0, "pops taken from an empty queue");
        fetch_enable <= 1'b1;
        wait_pops(8);

        run_load(addr_t'($random(seed)) & ~32'h3, 1'b1);
        run_load(addr_t'($random(seed)) & ~32'h3, 1'b1);
        wait_pops(4);

        repeat (10) @(posedge clk);
        if (load_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run("loads still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== bench/fetch_frontend_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_asserts (
    input logic clk,
    input logic rst,
    input logic full,          // queue status
    input logic empty,
    input logic load_grant,    // arbiter grants and returns
    input logic fetch_grant,
    input logic load_rvalid,
    input logic fetch_rvalid
);

    status_excl: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else $error("queue reports full and empty at once");

    grant_excl: assert property (@(posedge clk) disable iff (rst) !(load_grant && fetch_grant))
        else $error("load and fetch granted in the same cycle");

    load_return: assert property (@(posedge clk) disable iff (rst)
        load_grant |=> (load_rvalid && !fetch_rvalid))
        else $error("load grant not followed by a single load rvalid");

    fetch_return: assert property (@(posedge clk) disable iff (rst)
        fetch_grant |=> (fetch_rvalid && !load_rvalid))
        else $error("fetch grant not followed by a single fetch rvalid");

    // a return without a grant one cycle earlier would be a second rvalid
    no_stray_rvalid: assert property (@(posedge clk) disable iff (rst)
        (load_rvalid || fetch_rvalid) |-> $past(load_grant || fetch_grant))
        else $error("rvalid without a grant in the cycle before");

endmodule

// queue status and arbiter signals both live in the top level
bind fetch_frontend fetch_frontend_asserts fetch_frontend_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .full         (full),
    .empty        (empty),
    .load_grant   (load_grant),
    .fetch_grant  (fetch_grant),
    .load_rvalid  (load_rvalid),
    .fetch_rvalid (fetch_rvalid)
);

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend
    import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         fetch_enable,
    input  logic         branch_flush,
    input  addr_t        redirect_pc,
    input  logic         dequeue,
    output queue_entry_t rdata,
    output logic         empty,
    input  logic         load_start,
    input  addr_t        load_addr,
    output logic         load_busy,
    output logic         load_done,
    output word_t        load_data,
    input  logic         wr_en,
    input  addr_t        wr_addr,
    input  word_t        wr_data
);

    mem_req_t     fetch_req;
    mem_req_t     load_req_m;
    mem_req_t     mem_req;
    logic         fetch_grant;
    logic         load_grant;
    logic         fetch_rvalid;
    logic         load_rvalid;
    word_t        rd_data;     // shared return data
    logic         enqueue;
    logic         full;
    queue_entry_t wdata;

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_enable (fetch_enable),
        .branch_flush (branch_flush),
        .redirect_pc  (redirect_pc),
        .fetch_req    (fetch_req),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid),
        .rd_data      (rd_data),
        .full         (full),
        .enqueue      (enqueue),
        .wdata        (wdata)
    );

    load_port load_port_i (
        .clk         (clk),
        .rst         (rst),
        .load_start  (load_start),
        .load_addr   (load_addr),
        .load_busy   (load_busy),
        .load_done   (load_done),
        .load_data   (load_data),
        .load_req_m  (load_req_m),
        .load_grant  (load_grant),
        .load_rvalid (load_rvalid),
        .rd_data     (rd_data)
    );

    mem_arbiter mem_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .load_req_m   (load_req_m),
        .fetch_req    (fetch_req),
        .load_grant   (load_grant),
        .fetch_grant  (fetch_grant),
        .mem_req      (mem_req),
        .load_rvalid  (load_rvalid),
        .fetch_rvalid (fetch_rvalid)
    );

    unified_mem unified_mem_i (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    instr_queue instr_queue_i (
        .clk          (clk),
        .rst          (rst),
        .branch_flush (branch_flush),
        .wdata        (wdata),
        .enqueue      (enqueue),
        .dequeue      (dequeue),
        .rdata        (rdata),
        .full         (full),
        .empty        (empty)
    );

endmodule

`default_nettype wire

// ==== source/unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_frontend_settings.svh"

module unified_mem
    import rv32i_types::*;
(
    input  logic     clk,
    input  mem_req_t mem_req,
    output word_t    rd_data,
    input  logic     wr_en,
    input  addr_t    wr_addr,
    input  word_t    wr_data
);

    word_t      mem [`MEM_WORDS];
    mem_index_t rd_idx;
    mem_index_t wr_idx;

    // word index from byte address, low two bits ignored
    assign rd_idx = mem_req.addr[2 +: $bits(mem_index_t)];
    assign wr_idx = wr_addr[2 +: $bits(mem_index_t)];

    always_ff @(posedge clk) begin
        if (mem_req.rd) begin
            rd_data <= mem[rd_idx];  // old word on a same-cycle write
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t load_req_m,
    input  mem_req_t fetch_req,
    output logic     load_grant,
    output logic     fetch_grant,
    output mem_req_t mem_req,
    output logic     load_rvalid,
    output logic     fetch_rvalid
);

    logic load_won_q;   // last cycle's read belongs to the load port
    logic fetch_won_q;  // last cycle's read belongs to fetch

    // fixed priority, load first
    assign load_grant  = load_req_m.rd;
    assign fetch_grant = fetch_req.rd && !load_req_m.rd;

    always_comb begin
        if (load_grant) begin
            mem_req = load_req_m;
        end else begin
            mem_req = fetch_req;  // rd low here when nobody asks
        end
    end

    // steer the returning memory word to its owner
    assign load_rvalid  = load_won_q;
    assign fetch_rvalid = fetch_won_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_won_q  <= 1'b0;
            fetch_won_q <= 1'b0;
        end else begin
            load_won_q  <= load_grant;
            fetch_won_q <= fetch_grant;
        end
    end

endmodule

`default_nettype wire

// ==== source/load_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_port
    import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load_start,
    input  addr_t    load_addr,
    output logic     load_busy,
    output logic     load_done,
    output word_t    load_data,
    output mem_req_t load_req_m,
    input  logic     load_grant,
    input  logic     load_rvalid,
    input  word_t    rd_data
);

    logic  pending_q;  // request waiting for a grant
    addr_t addr_q;

    assign load_busy  = pending_q;
    assign load_req_m = '{rd: pending_q, addr: addr_q};

    // data comes back one cycle after the grant
    assign load_done = load_rvalid;
    assign load_data = rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (pending_q) begin
            if (load_grant) begin
                pending_q <= 1'b0;
            end
        end else if (load_start) begin
            pending_q <= 1'b1;  // start while busy is ignored
        end
    end

    always_ff @(posedge clk) begin
        if (load_start && !pending_q) begin
            addr_q <= load_addr;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_frontend_settings.svh"

module fetch_unit
    import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         fetch_enable,
    input  logic         branch_flush,
    input  addr_t        redirect_pc,
    output mem_req_t     fetch_req,
    input  logic         fetch_grant,
    input  logic         fetch_rvalid,
    input  word_t        rd_data,
    input  logic         full,
    output logic         enqueue,
    output queue_entry_t wdata
);

    fetch_state_t state_q;
    fetch_state_t state_next;
    addr_t        pc_q;           // next address to fetch
    addr_t        inflight_pc_q;  // address of the read in flight
    logic         fetch_rd;

    // no new read on a flush cycle, the pc is about to change
    assign fetch_rd  = (state_q == FETCH_IDLE) && fetch_enable && !full && !branch_flush;
    assign fetch_req = '{rd: fetch_rd, addr: pc_q};

    assign enqueue = (state_q == FETCH_WAIT) && fetch_rvalid && !branch_flush;
    assign wdata   = '{pc: inflight_pc_q, instr: rd_data};

    always_comb begin
        state_next = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (fetch_grant) begin
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (fetch_rvalid) begin
                    state_next = FETCH_IDLE;  // word goes to the queue or is flushed there
                end else if (branch_flush) begin
                    state_next = FETCH_DROP;
                end
            end
            FETCH_DROP: begin
                if (fetch_rvalid) begin
                    state_next = FETCH_IDLE;  // stale word discarded
                end
            end
            default: state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_IDLE;
            pc_q    <= `RESET_PC;
        end else begin
            state_q <= state_next;
            if (branch_flush) begin
                pc_q <= redirect_pc;
            end else if (fetch_grant) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_grant) begin
            inflight_pc_q <= pc_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_frontend_settings.svh"

module instr_queue
    import rv32i_types::*;
#(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         branch_flush,
    input  queue_entry_t wdata,
    input  logic         enqueue,
    input  logic         dequeue,
    output queue_entry_t rdata,
    output logic         full,
    output logic         empty
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W:0] head_q;     // top bit is the wrap bit
    logic [IDX_W:0] tail_q;
    logic [IDX_W:0] head_next;
    logic [IDX_W:0] tail_next;

    queue_entry_t     entries [DEPTH];
    logic [DEPTH-1:0] valid_q;  // per entry validity

    logic full_now;
    logic empty_now;
    logic do_enq;
    logic do_deq;

    // status of the pointers as they stand this cycle, used to gate operations
    assign full_now  = (tail_q[IDX_W-1:0] == head_q[IDX_W-1:0]) &&
                       (tail_q[IDX_W] != head_q[IDX_W]);
    assign empty_now = (tail_q[IDX_W-1:0] == head_q[IDX_W-1:0]) &&
                       (tail_q[IDX_W] == head_q[IDX_W]);

    assign do_enq = enqueue && !full_now && !branch_flush;  // flush wins
    assign do_deq = dequeue && !empty_now && !branch_flush;

    always_comb begin
        head_next = head_q;
        tail_next = tail_q;
        if (branch_flush) begin
            head_next = '0;
            tail_next = '0;
        end else begin
            if (do_enq) begin
                tail_next = tail_q + 1'b1;
            end
            if (do_deq) begin
                head_next = head_q + 1'b1;
            end
        end
    end

    // status after this cycle's operations
    assign full  = (tail_next[IDX_W-1:0] == head_next[IDX_W-1:0]) &&
                   (tail_next[IDX_W] != head_next[IDX_W]);
    assign empty = (tail_next[IDX_W-1:0] == head_next[IDX_W-1:0]) &&
                   (tail_next[IDX_W] == head_next[IDX_W]);

    always_comb begin
        if (empty_now && do_enq) begin
            rdata = wdata;  // entry lands this cycle, show it early
        end else if (valid_q[head_q[IDX_W-1:0]]) begin
            rdata = entries[head_q[IDX_W-1:0]];
        end else begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            valid_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
            if (branch_flush) begin
                valid_q <= '0;
            end else begin
                if (do_enq) begin
                    valid_q[tail_q[IDX_W-1:0]] <= 1'b1;
                end
                if (do_deq) begin
                    valid_q[head_q[IDX_W-1:0]] <= 1'b0;  // popped slot no longer valid
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            entries[tail_q[IDX_W-1:0]] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    typedef logic [31:0] word_t;       // instruction or data word
    typedef logic [31:0] addr_t;       // byte address
    typedef logic [7:0]  mem_index_t;  // word index, addr bits 9:2

    // one entry in the instruction queue
    typedef struct packed {
        addr_t pc;
        word_t instr;
    } queue_entry_t;

    // one read request towards the memory
    typedef struct packed {
        logic  rd;
        addr_t addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,  // free to issue a read
        FETCH_WAIT,  // read in flight, data comes next
        FETCH_DROP   // read in flight belongs to a flushed path
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== include/fetch_frontend_settings.svh ====
`ifndef FETCH_FRONTEND_SETTINGS_SVH
`define FETCH_FRONTEND_SETTINGS_SVH

// entries in the instruction queue, power of two
`define QUEUE_DEPTH 8

// 32-bit words in the unified memory
`define MEM_WORDS 256

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif
